// ==== hdl/nes_bus_pkg.sv ====
package nes_bus_pkg;

	typedef struct packed {
		logic        rd;      // Read strobe
		logic        wr;      // Write strobe
		logic [15:0] addr;
		logic [7:0]  wdata;
	} cpu_bus_t;

	typedef struct packed {
		logic       valid;    // One pulse per OAM byte
		logic [7:0] data;
	} oam_wr_t;

	localparam logic [15:0] ppu_base       = 16'h2000;
	localparam logic [15:0] ppu_top        = 16'h3FFF;  // Registers mirror every 8 bytes
	localparam logic [15:0] ram_top        = 16'h07FF;
	localparam logic [15:0] ram_mirror_top = 16'h1FFF;
	localparam logic [15:0] dma_reg        = 16'h4014;
	localparam logic [15:0] joypad_port    = 16'h4016;

	localparam logic [2:0] ppuctrl_ofs   = 3'd0;
	localparam logic [2:0] ppustatus_ofs = 3'd2;
	localparam logic [2:0] oamaddr_ofs   = 3'd3;
	localparam logic [2:0] oamdata_ofs   = 3'd4;

endpackage

// ==== hdl/nes_input_pkg.sv ====
package nes_input_pkg;

	// Serial order of the controller port, A shifts out first
	typedef struct packed {
		logic right;
		logic left;
		logic down;
		logic up;
		logic start;
		logic select;
		logic b;
		logic a;
	} joypad_t;

	localparam logic [7:0] code_a      = 8'h22;  // X
	localparam logic [7:0] code_b      = 8'h1A;  // Z
	localparam logic [7:0] code_select = 8'h59;  // Right shift
	localparam logic [7:0] code_start  = 8'h5A;  // Enter
	localparam logic [7:0] code_up     = 8'h1D;  // W
	localparam logic [7:0] code_down   = 8'h1B;  // S
	localparam logic [7:0] code_left   = 8'h1C;  // A
	localparam logic [7:0] code_right  = 8'h23;  // D
	localparam logic [7:0] code_break  = 8'hF0;

endpackage

// ==== hdl/ps2_receiver.sv ====
`timescale 1ns/1ps
module ps2_receiver #(
	parameter int ps2_filter = 4
)
(
	input  logic       CLOCK_50,
	input  logic       reset,
	input  logic       ps2_clk,
	input  logic       ps2_data,
	output logic [7:0] scancode,
	output logic       code_valid
);
	localparam int fw = $clog2(ps2_filter + 1);

	logic [1:0]    clk_sync;
	logic [1:0]    data_sync;
	logic [fw-1:0] stable_cnt;
	logic          clk_level;
	logic          clk_level_d;
	logic          fall;
	logic [3:0]    bit_cnt;
	logic [9:0]    shift;
	logic [10:0]   frame;

	assign fall  = clk_level_d & ~clk_level;
	assign frame = {data_sync[1], shift};  // Stop bit on top of start, data, parity

	always_ff @(posedge CLOCK_50 or posedge reset)
	begin
		if (reset)
		begin
			clk_sync    <= 2'b11;
			data_sync   <= 2'b11;
			stable_cnt  <= '0;
			clk_level   <= 1'b1;  // Idle bus is high
			clk_level_d <= 1'b1;
			bit_cnt     <= '0;
			shift       <= '0;
			scancode    <= '0;
			code_valid  <= 1'b0;
		end
		else
		begin
			clk_sync    <= {clk_sync[0], ps2_clk};
			data_sync   <= {data_sync[0], ps2_data};
			clk_level_d <= clk_level;
			code_valid  <= 1'b0;
			// Level must hold ps2_filter samples before it is taken
			if (clk_sync[1] == clk_level)
				stable_cnt <= '0;
			else if (stable_cnt == fw'(ps2_filter - 1))
			begin
				clk_level  <= clk_sync[1];
				stable_cnt <= '0;
			end
			else
				stable_cnt <= stable_cnt + 1'b1;
			if (fall)
			begin
				if (bit_cnt == 4'd10)
				begin
					bit_cnt <= '0;
					if (!frame[0] && frame[10] && ^frame[9:1])  // Start, stop, odd parity
					begin
						scancode   <= frame[8:1];
						code_valid <= 1'b1;
					end
				end
				else
				begin
					shift   <= {data_sync[1], shift[9:1]};  // LSB first
					bit_cnt <= bit_cnt + 1'b1;
				end
			end
		end
	end

endmodule

// ==== hdl/joypad_keys.sv ====
`timescale 1ns/1ps
module joypad_keys
	import nes_bus_pkg::*;
	import nes_input_pkg::*;
(
	input  logic       CLOCK_50,
	input  logic       reset,
	input  logic [7:0] scancode,
	input  logic       code_valid,
	input  cpu_bus_t   cpu,
	input  logic [7:0] rdata_in,
	output joypad_t    buttons,
	output logic [7:0] last_code,
	output logic [7:0] rdata_out
);
	logic       release_next;
	logic       strobe;
	logic [7:0] shift;
	logic [7:0] resp;
	logic       port_sel;
	joypad_t    key_mask;

	assign port_sel  = cpu.addr == joypad_port;
	assign rdata_out = resp | rdata_in;

	always_comb
	begin
		key_mask = '0;
		case (scancode)
			code_a:      key_mask.a = 1'b1;
			code_b:      key_mask.b = 1'b1;
			code_select: key_mask.select = 1'b1;
			code_start:  key_mask.start = 1'b1;
			code_up:     key_mask.up = 1'b1;
			code_down:   key_mask.down = 1'b1;
			code_left:   key_mask.left = 1'b1;
			code_right:  key_mask.right = 1'b1;
			default:     key_mask = '0;  // Unmapped keys change nothing
		endcase
	end

	always_ff @(posedge CLOCK_50 or posedge reset)
	begin
		if (reset)
		begin
			buttons      <= '0;
			release_next <= 1'b0;
			last_code    <= '0;
			strobe       <= 1'b0;
			shift        <= '0;
			resp         <= '0;
		end
		else
		begin
			resp <= 8'h00;
			if (code_valid)
			begin
				if (scancode == code_break)
					release_next <= 1'b1;  // Next code is a key release
				else
				begin
					release_next <= 1'b0;
					last_code    <= scancode;
					if (release_next)
						buttons <= buttons & ~key_mask;
					else
						buttons <= buttons | key_mask;
				end
			end
			if (cpu.wr && port_sel)
				strobe <= cpu.wdata[0];
			if (strobe)
				shift <= buttons;  // Transparent while strobe is high
			else if (cpu.rd && port_sel)
				shift <= {1'b1, shift[7:1]};  // Ones fill in after the eighth button
			if (cpu.rd && port_sel)
				resp <= {7'b0, shift[0]};
		end
	end

endmodule

// ==== hdl/wram_dma.sv ====
`timescale 1ns/1ps
module wram_dma
	import nes_bus_pkg::*;
(
	input  logic       CLOCK_50,
	input  logic       reset,
	input  cpu_bus_t   cpu,
	input  logic [7:0] rdata_in,
	output logic [7:0] rdata_out,
	output logic       rdy,
	output oam_wr_t    oam_wr,
	output logic [7:0] dma_page
);
	logic [7:0]  ram [0:2047];
	logic [15:0] mirrored;
	logic [7:0]  ram_q;
	logic        ram_sel;
	logic        busy;
	logic [8:0]  dma_cnt;
	logic        rd_hit;
	logic        oam_valid;

	assign ram_sel = cpu.addr <= ram_mirror_top;
	// DMA borrows the RAM port while the CPU is held
	assign mirrored = (busy ? {dma_page, dma_cnt[7:0]} : cpu.addr) & ram_top;

	assign rdy          = ~busy;
	assign oam_wr.valid = oam_valid;
	assign oam_wr.data  = ram_q;
	assign rdata_out    = (rd_hit ? ram_q : 8'h00) | rdata_in;

	always_ff @(posedge CLOCK_50)
	begin
		if (cpu.wr && ram_sel && !busy)
			ram[mirrored[10:0]] <= cpu.wdata;
		ram_q <= ram[mirrored[10:0]];
	end

	always_ff @(posedge CLOCK_50 or posedge reset)
	begin
		if (reset)
		begin
			busy      <= 1'b0;
			dma_cnt   <= '0;
			dma_page  <= '0;
			rd_hit    <= 1'b0;
			oam_valid <= 1'b0;
		end
		else
		begin
			rd_hit    <= cpu.rd && ram_sel && !busy;
			oam_valid <= busy && !dma_cnt[8];  // OAM write trails its read by one cycle
			if (busy)
			begin
				if (dma_cnt[8])
					busy <= 1'b0;  // Cycle 257 drains the last byte
				dma_cnt <= dma_cnt + 1'b1;
			end
			else if (cpu.wr && cpu.addr == dma_reg)
			begin
				busy     <= 1'b1;
				dma_page <= cpu.wdata;
				dma_cnt  <= '0;
			end
		end
	end

endmodule

// ==== hdl/ppu_regs.sv ====
`timescale 1ns/1ps
module ppu_regs
	import nes_bus_pkg::*;
#(
	parameter int h_total     = 8,
	parameter int v_total     = 10,
	parameter int vblank_line = 8
)
(
	input  logic       CLOCK_50,
	input  logic       reset,
	input  cpu_bus_t   cpu,
	input  logic [7:0] rdata_in,
	input  oam_wr_t    oam_wr,
	output logic [7:0] rdata,
	output logic       nmi_n,
	output logic       hsync,
	output logic       vsync,
	output logic [7:0] oam_addr
);
	localparam int hw = $clog2(h_total);
	localparam int vw = $clog2(v_total);

	logic [hw-1:0] h_cnt;
	logic [vw-1:0] v_cnt;
	logic [vw-1:0] v_next;
	logic          line_end;
	logic          vblank;
	logic          nmi_en;  // PPUCTRL bit 7
	logic          ppu_sel;
	logic [2:0]    reg_ofs;
	logic          oam_we;
	logic [7:0]    oam_wdata;
	logic [7:0]    oam [0:255];
	logic [7:0]    rd_mux;
	logic [7:0]    resp;

	assign line_end  = h_cnt == hw'(h_total - 1);
	assign v_next    = (v_cnt == vw'(v_total - 1)) ? '0 : v_cnt + 1'b1;
	assign hsync     = line_end;
	assign ppu_sel   = (cpu.addr >= ppu_base) && (cpu.addr <= ppu_top);
	assign reg_ofs   = cpu.addr[2:0];  // 8-byte mirror
	assign oam_we    = oam_wr.valid || (cpu.wr && ppu_sel && reg_ofs == oamdata_ofs);
	assign oam_wdata = oam_wr.valid ? oam_wr.data : cpu.wdata;
	assign rdata     = resp | rdata_in;

	always_comb
	begin
		case (reg_ofs)
			ppustatus_ofs: rd_mux = {vblank, 7'b0};
			oamdata_ofs:   rd_mux = oam[oam_addr];
			default:       rd_mux = 8'h00;  // Write-only registers
		endcase
	end

	always_ff @(posedge CLOCK_50)
	begin
		if (oam_we)
			oam[oam_addr] <= oam_wdata;
	end

	always_ff @(posedge CLOCK_50 or posedge reset)
	begin
		if (reset)
		begin
			h_cnt    <= '0;
			v_cnt    <= '0;
			vblank   <= 1'b0;
			nmi_en   <= 1'b0;
			oam_addr <= '0;
			resp     <= '0;
			vsync    <= 1'b0;
			nmi_n    <= 1'b1;
		end
		else
		begin
			h_cnt <= line_end ? '0 : h_cnt + 1'b1;
			if (line_end)
				v_cnt <= v_next;
			vsync <= v_cnt >= vblank_line;  // Same lag as nmi_n
			nmi_n <= ~(vblank && nmi_en);
			resp  <= (cpu.rd && ppu_sel) ? rd_mux : 8'h00;
			if (cpu.rd && ppu_sel && reg_ofs == ppustatus_ofs)
				vblank <= 1'b0;  // Read returns the old flag
			if (line_end && v_next == vblank_line)
				vblank <= 1'b1;
			else if (line_end && v_next == '0)
				vblank <= 1'b0;
			if (cpu.wr && ppu_sel && reg_ofs == ppuctrl_ofs)
				nmi_en <= cpu.wdata[7];
			if (oam_we)
				oam_addr <= oam_addr + 1'b1;
			else if (cpu.wr && ppu_sel && reg_ofs == oamaddr_ofs)
				oam_addr <= cpu.wdata;
		end
	end

endmodule

// ==== hdl/hex_driver.sv ====
`timescale 1ns/1ps
module hex_driver
(
	input  logic [3:0] nibble,
	output logic [6:0] segments  // g down to a, low lights
);
	always_comb
	begin
		case (nibble)
			4'h0: segments = 7'b1000000;
			4'h1: segments = 7'b1111001;
			4'h2: segments = 7'b0100100;
			4'h3: segments = 7'b0110000;
			4'h4: segments = 7'b0011001;
			4'h5: segments = 7'b0010010;
			4'h6: segments = 7'b0000010;
			4'h7: segments = 7'b1111000;
			4'h8: segments = 7'b0000000;
			4'h9: segments = 7'b0010000;
			4'hA: segments = 7'b0001000;
			4'hB: segments = 7'b0000011;
			4'hC: segments = 7'b1000110;
			4'hD: segments = 7'b0100001;
			4'hE: segments = 7'b0000110;
			default: segments = 7'b0001110;  // F
		endcase
	end

endmodule

// ==== hdl/fpga_nes.sv ====
`timescale 1ns/1ps
module fpga_nes
	import nes_bus_pkg::*;
	import nes_input_pkg::*;
#(
	parameter int h_total     = 8,
	parameter int v_total     = 10,
	parameter int vblank_line = 8,
	parameter int ps2_filter  = 4
)
(
	input  logic            CLOCK_50,
	input  logic            reset,
	input  logic            ps2_clk,
	input  logic            ps2_data,
	input  cpu_bus_t        cpu,
	output logic [7:0]      rdata,
	output logic            rdy,
	output logic            nmi_n,
	output logic            hsync,
	output logic            vsync,
	output logic [7:0][6:0] hex
);
	logic [7:0]      scancode;
	logic            code_valid;
	joypad_t         buttons;
	logic [7:0]      last_code;
	logic [7:0]      joy_rdata;  // Read chain, joypad first
	logic [7:0]      ram_rdata;
	logic [7:0]      dma_page;
	logic [7:0]      oam_addr;
	oam_wr_t         oam_wr;
	logic [7:0][3:0] nibbles;

	assign nibbles = {buttons, last_code, dma_page, oam_addr};  // Digit 0 is lowest

	ps2_receiver #(.ps2_filter(ps2_filter)) keyboard (.CLOCK_50, .reset, .ps2_clk, .ps2_data,
		.scancode, .code_valid);

	joypad_keys pad (.CLOCK_50, .reset, .scancode, .code_valid, .cpu, .rdata_in(8'h00),
		.buttons, .last_code, .rdata_out(joy_rdata));

	wram_dma work_ram (.CLOCK_50, .reset, .cpu, .rdata_in(joy_rdata), .rdata_out(ram_rdata),
		.rdy, .oam_wr, .dma_page);

	ppu_regs #(.h_total(h_total), .v_total(v_total), .vblank_line(vblank_line)) ppu (
		.CLOCK_50, .reset, .cpu, .rdata_in(ram_rdata), .oam_wr, .rdata, .nmi_n, .hsync,
		.vsync, .oam_addr);

	hex_driver hex_drivers[7:0] (.nibble(nibbles), .segments(hex));

endmodule

// ==== testbench/fpga_nes_sva.sv ====
`timescale 1ns/1ps
module fpga_nes_sva
	import nes_bus_pkg::*;
(
	input logic     CLOCK_50,
	input logic     reset,
	input cpu_bus_t cpu,
	input logic     rdy,
	input logic     nmi_n,
	input logic     vsync
);
	int fail_count = 0;  // Assertion failures so far

	property no_strobe_while_held;
		@(posedge CLOCK_50) disable iff (reset)
			!rdy |-> !(cpu.rd || cpu.wr);
	endproperty

	// One RAM read per OAM byte plus the drain cycle
	property dma_hold_length;
		@(posedge CLOCK_50) disable iff (reset)
			(rdy && cpu.wr && cpu.addr == dma_reg) |=> !rdy [*257] ##1 rdy;
	endproperty

	property nmi_only_in_vblank;
		@(posedge CLOCK_50) disable iff (reset)
			!vsync |-> nmi_n;
	endproperty

	assert property (no_strobe_while_held)
	else
	begin
		fail_count++;
		$error("CPU strobe while rdy is low");
	end

	assert property (dma_hold_length)
	else
	begin
		fail_count++;
		$error("rdy not held low for 257 cycles after the DMA write");
	end

	assert property (nmi_only_in_vblank)
	else
	begin
		fail_count++;
		$error("nmi_n low outside vsync");
	end

endmodule

bind fpga_nes fpga_nes_sva bus_checks (.CLOCK_50, .reset, .cpu, .rdy, .nmi_n, .vsync);

// ==== testbench/tb_fpga_nes.sv ====
`timescale 1ns/1ps
module tb_fpga_nes
	import nes_bus_pkg::*;
;
	// Active-low segments for 0 to F with F on top
	localparam logic [15:0][6:0] seg_table = {7'h0E, 7'h06, 7'h21, 7'h46, 7'h03, 7'h08,
		7'h10, 7'h00, 7'h78, 7'h02, 7'h12, 7'h19, 7'h30, 7'h24, 7'h79, 7'h40};

	localparam int h_total     = 8;
	localparam int v_total     = 10;
	localparam int vblank_line = 8;

	logic            CLOCK_50;
	logic            reset;
	logic            ps2_clk;
	logic            ps2_data;
	cpu_bus_t        cpu;
	logic [7:0]      rdata;
	logic            rdy;
	logic            nmi_n;
	logic            hsync;
	logic            vsync;
	logic [7:0][6:0] hex;

	logic [7:0]  ops [0:63];
	logic [31:0] addrs [0:63];
	logic [31:0] datas [0:63];
	logic [31:0] exps [0:63];
	logic [7:0]  oam_expect [0:255];  // Bytes the DMA should land in OAM
	logic [31:0] rng;
	int          num_tests;
	int          errors;
	int          failed_tests;
	int          cycles;
	int          cycle_limit;

	fpga_nes #(.h_total(h_total), .v_total(v_total), .vblank_line(vblank_line),
		.ps2_filter(4)) UUT (
		.CLOCK_50, .reset, .ps2_clk, .ps2_data, .cpu, .rdata, .rdy, .nmi_n, .hsync, .vsync,
		.hex);

	initial
	begin
		CLOCK_50 = 1'b0;
		forever #2 CLOCK_50 = ~CLOCK_50;
	end

	always @(posedge CLOCK_50)
	begin
		cycles++;
		if (cycle_limit != 0 && cycles > cycle_limit)
		begin
			$display("Timeout after %0d cycles, the DUT stopped responding", cycles);
			$display("CHECKS FAILED");
			$finish;
		end
	end

	function automatic logic [31:0] xorshift(input logic [31:0] x);
		logic [31:0] y;
		begin
			y = x ^ (x << 13);
			y = y ^ (y >> 17);
			y = y ^ (y << 5);
			return y;
		end
	endfunction

	task automatic report_mismatch(input string name, input logic [31:0] want,
		input logic [31:0] seen);
		begin
			$display("FAILED %s expected %h got %h", name, want, seen);
			errors++;
		end
	endtask

	// Comment lines start with # and other lines hold op, addr, data and expected
	task automatic load_tests();
		integer           fd;
		integer           code;
		logic [7:0]       op;
		logic [8*128-1:0] rest;
		logic [31:0]      a;
		logic [31:0]      d;
		logic [31:0]      e;
		begin
			num_tests = 0;
			fd = $fopen("testbench/nes_tests.txt", "r");
			if (fd != 0)
			begin
				while (!$feof(fd) && num_tests < 64)
				begin
					code = $fscanf(fd, " %c", op);
					if (code == 1 && op == "#")
						code = $fgets(rest, fd);
					else if (code == 1)
					begin
						code = $fscanf(fd, "%h %h %h", a, d, e);
						ops[num_tests]   = op;
						addrs[num_tests] = a;
						datas[num_tests] = d;
						exps[num_tests]  = e;
						num_tests++;
					end
				end
				$fclose(fd);
			end
		end
	endtask

	// Called on a falling edge and returns on the next one
	task automatic bus_write(input logic [15:0] addr, input logic [7:0] data);
		begin
			cpu.addr  = addr;
			cpu.wdata = data;
			cpu.wr    = 1'b1;
			@(negedge CLOCK_50);
			cpu.wr = 1'b0;
		end
	endtask

	task automatic bus_read(input logic [15:0] addr, output logic [7:0] data);
		begin
			cpu.addr = addr;
			cpu.rd   = 1'b1;
			@(negedge CLOCK_50);
			cpu.rd = 1'b0;
			data   = rdata;  // Registered response from the last edge
		end
	endtask

	task automatic send_ps2(input logic [7:0] code, input logic bad_parity);
		logic [10:0] frame;
		int          i;
		begin
			frame = {1'b1, ~^code ^ bad_parity, code, 1'b0};  // Stop, odd parity, data, start
			for (i = 0; i < 11; i++)
			begin
				ps2_data = frame[i];
				repeat (8) @(negedge CLOCK_50);
				ps2_clk = 1'b0;
				repeat (8) @(negedge CLOCK_50);
				ps2_clk = 1'b1;
			end
			ps2_data = 1'b1;
			repeat (20) @(negedge CLOCK_50);
		end
	endtask

	task automatic check_hex(input int digit, input logic [7:0] value);
		logic [13:0] want;
		logic [13:0] seen;
		begin
			want = {seg_table[value[7:4]], seg_table[value[3:0]]};
			seen = {hex[digit + 1], hex[digit]};
			if (seen !== want)
				report_mismatch($sformatf("hex[%0d:%0d]", digit + 1, digit), want, seen);
		end
	endtask

	// Measures one line period and the length of the next vsync pulse
	task automatic check_sync_timing();
		int gap;
		int high;
		begin
			while (hsync !== 1'b1)
				@(negedge CLOCK_50);
			@(negedge CLOCK_50);
			gap = 1;
			while (hsync !== 1'b1)
			begin
				@(negedge CLOCK_50);
				gap++;
			end
			if (gap != h_total)
				report_mismatch("hsync period", h_total, gap);
			while (vsync === 1'b1)
				@(negedge CLOCK_50);
			while (vsync !== 1'b1)
				@(negedge CLOCK_50);
			high = 0;
			while (vsync === 1'b1)
			begin
				high++;
				@(negedge CLOCK_50);
			end
			if (high != (v_total - vblank_line) * h_total)
				report_mismatch("vsync high cycles", (v_total - vblank_line) * h_total, high);
		end
	endtask

	task automatic check_nmi(input logic wait_vblank, input logic expect_n);
		begin
			if (wait_vblank)
			begin
				check_sync_timing();
				while (vsync === 1'b1)
					@(negedge CLOCK_50);
				while (vsync !== 1'b1)
					@(negedge CLOCK_50);
			end
			else
				@(negedge CLOCK_50);
			if (nmi_n !== expect_n)
				report_mismatch("nmi_n", expect_n, nmi_n);
			while (wait_vblank && expect_n && vsync === 1'b1)  // Disabled NMI stays quiet
			begin
				@(negedge CLOCK_50);
				if (nmi_n !== 1'b1)
					report_mismatch("nmi_n", 1, nmi_n);
			end
		end
	endtask

	task automatic run_dma(input logic [7:0] page, input logic [7:0] start,
		input logic [31:0] hold_cycles);
		logic [7:0] got;
		int         i;
		int         low_cycles;
		begin
			for (i = 0; i < 256; i++)
			begin
				rng = xorshift(rng);
				oam_expect[i] = rng[7:0];
				bus_write({page, i[7:0]}, rng[7:0]);
			end
			bus_write(16'h2003, start);
			bus_write(dma_reg, page);
			low_cycles = 0;
			if (rdy !== 1'b0)
			begin
				$display("rdy did not fall after the DMA register write");
				errors++;
			end
			while (rdy === 1'b0)
			begin
				low_cycles++;
				@(negedge CLOCK_50);
			end
			if (low_cycles != hold_cycles)
				report_mismatch("rdy low cycles", hold_cycles, low_cycles);
			check_hex(0, start);  // 256 increments wrap OAMADDR
			for (i = 0; i < 256; i++)
			begin
				bus_write(16'h2003, start + i[7:0]);
				bus_read(16'h2004, got);
				if (got !== oam_expect[i])
					report_mismatch($sformatf("OAM[%h]", start + i[7:0]), oam_expect[i], got);
			end
		end
	endtask

	initial
	begin
		logic [7:0] got;
		int         errors_before;
		int         t;
		reset        = 1'b1;
		ps2_clk      = 1'b1;
		ps2_data     = 1'b1;
		cpu          = '0;
		rng          = 32'hf825;
		errors       = 0;
		failed_tests = 0;
		cycles       = 0;
		cycle_limit  = 0;
		load_tests();
		if (num_tests == 0)
		begin
			$display("No tests could be read from testbench/nes_tests.txt");
			errors = 1;
		end
		else
		begin
			cycle_limit = num_tests * 600 + 100;
			repeat (8) @(negedge CLOCK_50);
			reset = 1'b0;
			@(negedge CLOCK_50);
			for (t = 0; t < num_tests; t++)
			begin
				errors_before = errors;
				case (ops[t])
					"W": bus_write(addrs[t][15:0], datas[t][7:0]);
					"R":
					begin
						bus_read(addrs[t][15:0], got);
						if (got !== exps[t][7:0])
							report_mismatch("rdata", exps[t][7:0], got);
					end
					"K": send_ps2(addrs[t][7:0], datas[t][0]);
					"H": check_hex(addrs[t], exps[t][7:0]);
					"N": check_nmi(addrs[t][0], exps[t][0]);
					"D": run_dma(addrs[t][7:0], datas[t][7:0], exps[t]);
					default:
					begin
						$display("Unknown operation %c in test %0d", ops[t], t);
						errors++;
					end
				endcase
				if (errors != errors_before)
					failed_tests++;
				$display("test %0d %c %h: %s", t, ops[t], addrs[t][15:0],
					(errors == errors_before) ? "pass" : "fail");
			end
		end
		errors += UUT.bus_checks.fail_count;
		$display("tests run: %0d  tests failed: %0d  check errors: %0d", num_tests,
			failed_tests, errors);
		if (errors == 0)
			$display("ALL CHECKS PASSED");
		else
			$display("CHECKS FAILED");
		$finish;
	end

endmodule

// ==== compile.f ====
hdl/nes_bus_pkg.sv
hdl/nes_input_pkg.sv
hdl/ps2_receiver.sv
hdl/joypad_keys.sv
hdl/wram_dma.sv
hdl/ppu_regs.sv
hdl/hex_driver.sv
hdl/fpga_nes.sv
testbench/fpga_nes_sva.sv
testbench/tb_fpga_nes.sv

// ==== testbench/nes_tests.txt ====
# op addr/code data expected, all hex. W write, R read, K PS/2 byte (data 1 = bad parity)
# H hex pair from digit addr, N nmi_n (addr 1 waits for vblank), D DMA page (data = OAMADDR)
W 0123 5a 00
R 0923 00 5a
R 5000 00 00
K 0022 00 00
K 001a 00 00
K 005a 00 00
H 0006 00 0b
H 0004 00 5a
W 4016 01 00
W 4016 00 00
R 4016 00 01
R 4016 00 01
R 4016 00 00
R 4016 00 01
R 4016 00 00
R 4016 00 00
R 4016 00 00
R 4016 00 00
R 4016 00 01
K 00f0 00 00
K 0022 00 00
K 001c 01 00
H 0006 00 0a
H 0004 00 22
K 00f0 00 00
K 001a 00 00
K 00f0 00 00
K 005a 00 00
H 0006 00 00
H 0004 00 5a
D 000d 40 101
H 0002 00 0d
W 2003 10 00
W 2004 77 00
H 0000 00 11
W 2003 10 00
R 2004 00 77
H 0000 00 10
W 2000 00 00
N 0001 00 01
W 2000 80 00
N 0001 00 00
R 2002 00 80
R 2002 00 00
N 0000 00 01
